// ==== src/npcPkg.sv ====
package npcPkg;

    // ----------------------------------------
    // Basic widths
    // ----------------------------------------

    // Machine word for data, addresses and instructions
    typedef logic [31:0] wordT;

    // Register index, x0 to x31
    typedef logic [4:0] regAddrT;

    // Raw I-type immediate before sign extension
    typedef logic [11:0] immT;

    // ----------------------------------------
    // Enumerations
    // ----------------------------------------

    // Decoded instruction class
    typedef enum logic [1:0] {
        instAddi,
        instJalr,
        instEbreak,
        instIllegal
    } instTypeE;

    // Core control states
    typedef enum logic [1:0] {
        coreReset,
        coreRun,
        coreHalt
    } coreStateE;

    // Why the core stopped
    typedef enum logic [1:0] {
        haltNone,
        haltEbreak,
        haltIllegal
    } haltCauseE;

    // ----------------------------------------
    // Structs
    // ----------------------------------------

    // Decoder output bundle
    typedef struct packed {
        instTypeE kind;
        regAddrT  rs1;
        regAddrT  rd;
        // Already sign-extended to a full word
        wordT     imm;
        logic     regWen;
    } decodeT;

    // Per-cycle retire trace
    typedef struct packed {
        logic    valid;
        wordT    pc;
        wordT    inst;
        logic    wen;
        regAddrT rd;
        wordT    wdata;
    } commitT;

endpackage

// ==== src/npcPc.sv ====
`timescale 1ns/100ps

module npcPc
    import npcPkg::*;
#(
    parameter wordT resetPc = 32'h8000_0000
) (
    input  logic clk,
    input  logic arstN,
    input  logic pcStep,
    input  logic pcLoad,
    input  wordT jumpTarget,
    output wordT pc
);

    // Next PC candidates
    wordT pcNext;
    wordT pcSeq;

    // Sequential successor
    assign pcSeq = pc + 32'd4;

    // Strobes are exclusive, load checked first anyway
    always_comb begin
        pcNext = pc;
        if (pcLoad) begin
            pcNext = jumpTarget;
        end else if (pcStep) begin
            pcNext = pcSeq;
        end
    end

    // ----------------------------------------
    // PC register
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else begin
            // Holds when neither strobe is set
            pc <= pcNext;
        end
    end

endmodule

// ==== src/npcDecoder.sv ====
`timescale 1ns/100ps

module npcDecoder
    import npcPkg::*;
(
    input  wordT   inst,
    output decodeT dec
);

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    // OP-IMM major opcode, addi lives here
    localparam logic [6:0] opAluImm = 7'b0010011;
    // JALR major opcode
    localparam logic [6:0] opJalr   = 7'b1100111;
    // Both supported instructions use funct3 zero
    localparam logic [2:0] f3Zero   = 3'b000;
    // Full ebreak word, no field matching
    localparam wordT       ebreakWord = 32'h0010_0073;

    // ----------------------------------------
    // Field split
    // ----------------------------------------
    logic [6:0] opcode;
    logic [2:0] funct3;
    regAddrT    rs1;
    regAddrT    rd;
    immT        immRaw;
    wordT       immExt;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign immRaw = inst[31:20];

    // Sign extend from bit 11
    assign immExt = {{20{immRaw[11]}}, immRaw};

    // ----------------------------------------
    // Classification
    // ----------------------------------------
    instTypeE kind;

    always_comb begin
        // Default trap for anything unknown
        kind = instIllegal;
        if (inst == ebreakWord) begin
            kind = instEbreak;
        end else if (opcode == opAluImm && funct3 == f3Zero) begin
            kind = instAddi;
        end else if (opcode == opJalr && funct3 == f3Zero) begin
            kind = instJalr;
        end
    end

    // Output bundle
    always_comb begin
        dec.kind   = kind;
        dec.rs1    = rs1;
        dec.rd     = rd;
        dec.imm    = immExt;
        // Only addi and jalr write a register
        dec.regWen = (kind == instAddi) || (kind == instJalr);
    end

endmodule

// ==== src/npcRegFile.sv ====
`timescale 1ns/100ps

module npcRegFile
    import npcPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    wen,
    input  regAddrT waddr,
    input  wordT    wdata,
    input  regAddrT raddr,
    output wordT    rdata
);

    // x1 to x31, x0 has no storage
    wordT regs [1:31];

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Writes to x0 fall away here
            if (wen && waddr != 5'd0) begin
                regs[waddr] <= wdata;
            end
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Combinational, x0 hardwired to zero
    always_comb begin
        if (raddr == 5'd0) begin
            rdata = '0;
        end else begin
            rdata = regs[raddr];
        end
    end

endmodule

// ==== src/npcExecute.sv ====
`timescale 1ns/100ps

module npcExecute
    import npcPkg::*;
(
    input  wordT pc,
    input  wordT rs1Value,
    input  wordT imm,
    output wordT aluResult,
    output wordT jumpTarget,
    output wordT linkValue
);

    // Raw jalr sum before alignment
    wordT jumpSum;

    // ----------------------------------------
    // addi
    // ----------------------------------------

    // Overflow wraps, no exception in RV32I
    assign aluResult = rs1Value + imm;

    // ----------------------------------------
    // jalr
    // ----------------------------------------

    // Separate adder from the ALU path
    assign jumpSum = rs1Value + imm;

    // Bit 0 always cleared for jalr
    assign jumpTarget = {jumpSum[31:1], 1'b0};

    // Return address
    assign linkValue = pc + 32'd4;

endmodule

// ==== src/npcControl.sv ====
`timescale 1ns/100ps

module npcControl
    import npcPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  decodeT    dec,
    output logic      regWrite,
    output logic      pcStep,
    output logic      pcLoad,
    output logic      retire,
    output coreStateE state,
    output haltCauseE haltCause
);

    coreStateE stateNext;
    haltCauseE causeNext;
    logic      running;
    logic      stopInst;

    // One instruction per cycle while running
    assign running  = (state == coreRun);
    // ebreak and illegal both end execution
    assign stopInst = (dec.kind == instEbreak) || (dec.kind == instIllegal);

    // ----------------------------------------
    // Strobes
    // ----------------------------------------
    assign retire   = running;
    assign regWrite = running && dec.regWen;
    assign pcStep   = running && (dec.kind == instAddi);
    assign pcLoad   = running && (dec.kind == instJalr);

    // ----------------------------------------
    // Next state and cause
    // ----------------------------------------
    always_comb begin
        stateNext = state;
        causeNext = haltCause;
        case (state)
            // Leave reset on the first edge
            coreReset: stateNext = coreRun;
            coreRun: begin
                if (stopInst) begin
                    stateNext = coreHalt;
                    causeNext = (dec.kind == instEbreak) ? haltEbreak : haltIllegal;
                end
            end
            // Stuck until reset
            coreHalt: stateNext = coreHalt;
            default:  stateNext = coreReset;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= coreReset;
            haltCause <= haltNone;
        end else begin
            state     <= stateNext;
            haltCause <= causeNext;
        end
    end

endmodule

// ==== src/npcCore.sv ====
`timescale 1ns/100ps

module npcCore
    import npcPkg::*;
#(
    // First fetch address
    parameter wordT resetPc = 32'h8000_0000
) (
    input  logic      clk,
    input  logic      arstN,
    output wordT      instAddr,
    input  wordT      instData,
    output commitT    commit,
    output coreStateE state,
    output haltCauseE haltCause
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------
    wordT   pc;
    decodeT dec;
    wordT   rs1Value;
    wordT   aluResult;
    wordT   jumpTarget;
    wordT   linkValue;
    wordT   wbData;
    logic   regWrite;
    logic   pcStep;
    logic   pcLoad;
    logic   retire;

    // Fetch straight from the PC
    assign instAddr = pc;

    npcPc #(
        .resetPc(resetPc)
    ) pc0 (
        .clk       (clk),
        .arstN     (arstN),
        .pcStep    (pcStep),
        .pcLoad    (pcLoad),
        .jumpTarget(jumpTarget),
        .pc        (pc)
    );

    npcDecoder decoder0 (
        .inst(instData),
        .dec (dec)
    );

    // Link value for jalr, sum for addi
    assign wbData = (dec.kind == instJalr) ? linkValue : aluResult;

    npcRegFile regFile0 (
        .clk  (clk),
        .arstN(arstN),
        .wen  (regWrite),
        .waddr(dec.rd),
        .wdata(wbData),
        .raddr(dec.rs1),
        .rdata(rs1Value)
    );

    npcExecute execute0 (
        .pc        (pc),
        .rs1Value  (rs1Value),
        .imm       (dec.imm),
        .aluResult (aluResult),
        .jumpTarget(jumpTarget),
        .linkValue (linkValue)
    );

    npcControl control0 (
        .clk      (clk),
        .arstN    (arstN),
        .dec      (dec),
        .regWrite (regWrite),
        .pcStep   (pcStep),
        .pcLoad   (pcLoad),
        .retire   (retire),
        .state    (state),
        .haltCause(haltCause)
    );

    // ----------------------------------------
    // Commit trace
    // ----------------------------------------

    // x0 writes still show wen high
    always_comb begin
        commit.valid = retire;
        commit.pc    = pc;
        commit.inst  = instData;
        commit.wen   = regWrite;
        commit.rd    = dec.rd;
        commit.wdata = wbData;
    end

endmodule

// ==== verif/npcCoreTb.sv ====
`timescale 1ns/100ps

module npcCoreTb
    import npcPkg::*;
();

    localparam wordT bootPc     = 32'h8000_0000;
    localparam wordT ebreakInst = 32'h0010_0073;
    // Cycles allowed for one program to reach a halt
    localparam int   haltLimit  = 200;

    logic      clk = 1'b0;
    logic      arstN;
    wordT      instAddr;
    wordT      instData;
    commitT    commit;
    coreStateE state;
    haltCauseE haltCause;

    // Instruction ROM of 256 words
    wordT rom [0:255];
    wordT romOffset;

    // Reference model state
    wordT      refPc;
    wordT      refRegs [0:31];
    haltCauseE refCause;
    commitT    expected;
    int        errors  = 0;
    int        commits = 0;

    always #10 clk = ~clk;

    npcCore #(
        .resetPc(bootPc)
    ) dut0 (
        .clk      (clk),
        .arstN    (arstN),
        .instAddr (instAddr),
        .instData (instData),
        .commit   (commit),
        .state    (state),
        .haltCause(haltCause)
    );

    // ROM aliases across the whole address space
    assign romOffset = (instAddr - bootPc) >> 2;
    assign instData  = rom[romOffset[7:0]];

    // ----------------------------------------
    // Encoders and reference model
    // ----------------------------------------
    function automatic wordT addiWord(input regAddrT rd, input regAddrT rs1, input immT imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic wordT jalrWord(input regAddrT rd, input regAddrT rs1, input immT imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // Same aliasing as the ROM port
    function automatic wordT romWord(input wordT addr);
        wordT offset;
        offset = (addr - bootPc) >> 2;
        return rom[offset[7:0]];
    endfunction

    // Retires one instruction and updates model PC and registers
    function automatic commitT refStep(input wordT inst);
        commitT  c;
        wordT    immVal;
        wordT    target;
        regAddrT rd;
        regAddrT rs1;
        immVal  = {{20{inst[31]}}, inst[31:20]};
        rd      = inst[11:7];
        rs1     = inst[19:15];
        c       = '0;
        c.valid = 1'b1;
        c.pc    = refPc;
        c.inst  = inst;
        c.rd    = rd;
        if (inst[14:12] == 3'b000 && inst[6:0] == 7'b0010011) begin
            c.wen   = 1'b1;
            c.wdata = refRegs[rs1] + immVal;
            refPc   = refPc + 32'd4;
        end else if (inst[14:12] == 3'b000 && inst[6:0] == 7'b1100111) begin
            // Target taken before the link write since rd may equal rs1
            c.wen   = 1'b1;
            c.wdata = refPc + 32'd4;
            target  = refRegs[rs1] + immVal;
            refPc   = {target[31:1], 1'b0};
        end else begin
            // PC holds on a halting instruction
            refCause = (inst == ebreakInst) ? haltEbreak : haltIllegal;
        end
        // x0 stays zero
        if (c.wen && rd != 5'd0) begin
            refRegs[rd] = c.wdata;
        end
        return c;
    endfunction

    task automatic compareWord(input string name, input wordT exp, input wordT act);
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ----------------------------------------
    // Commit checker
    // ----------------------------------------
    always @(posedge clk) begin
        if (state === coreRun) begin
            expected = refStep(romWord(refPc));
            commits++;
            compareWord("commit.valid", expected.valid, commit.valid);
            compareWord("commit.pc", expected.pc, commit.pc);
            compareWord("commit.inst", expected.inst, commit.inst);
            compareWord("commit.wen", expected.wen, commit.wen);
            // rd and data only defined for a write
            if (expected.wen) begin
                compareWord("commit.rd", expected.rd, commit.rd);
                compareWord("commit.wdata", expected.wdata, commit.wdata);
            end
        end else if (commit.valid === 1'b1) begin
            errors++;
            $display("A commit was reported while the core was not running");
        end
    end

    // ----------------------------------------
    // Sequencing tasks
    // ----------------------------------------
    task automatic clearRom();
        int i;
        // Unused words hold an illegal opcode tagged with their index
        for (i = 0; i < 256; i++) begin
            rom[i] <= {i[7:0], 24'h00_0007};
        end
    endtask

    task automatic resetCore();
        int r;
        @(posedge clk);
        arstN    <= 1'b0;
        refPc    = bootPc;
        refCause = haltNone;
        for (r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        repeat (10) begin
            @(posedge clk);
            compareWord("instAddr", bootPc, instAddr);
            compareWord("commit.valid", 32'd0, commit.valid);
            compareWord("state", coreReset, state);
            compareWord("haltCause", haltNone, haltCause);
        end
        arstN <= 1'b1;
        // First edge after release still shows reset
        @(posedge clk);
        compareWord("state", coreReset, state);
        compareWord("instAddr", bootPc, instAddr);
        @(posedge clk);
        compareWord("state", coreRun, state);
    endtask

    task automatic runToHalt(input haltCauseE cause, input string name);
        int n;
        n = 0;
        while (state !== coreHalt && n < haltLimit) begin
            @(posedge clk);
            n++;
        end
        if (state !== coreHalt) begin
            errors++;
            $display("Program %s: the core never halted", name);
        end else begin
            compareWord("haltCause", cause, haltCause);
            compareWord("model halt cause", cause, refCause);
            // PC stays on the halting instruction
            repeat (20) begin
                @(posedge clk);
                compareWord("instAddr", refPc, instAddr);
                compareWord("state", coreHalt, state);
                compareWord("haltCause", cause, haltCause);
            end
        end
    endtask

    // x30 holds a link near the ROM base and jumps only go forward
    task automatic loadRandomProgram();
        int i;
        int k;
        rom[0] <= jalrWord(5'd30, 5'd0, 12'd4);
        for (i = 1; i <= 40; i++) begin
            if ($urandom_range(3) == 0) begin
                k = i + 1 + $urandom_range(40 - i);
                // Low bit sometimes set to exercise the clear
                rom[i] <= jalrWord(regAddrT'($urandom_range(29)), 5'd30,
                                   immT'(4 * k - 4 + $urandom_range(1)));
            end else begin
                rom[i] <= addiWord(regAddrT'($urandom_range(29)),
                                   regAddrT'($urandom_range(30)), immT'($urandom));
            end
        end
        rom[41] <= ebreakInst;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h9329));
        arstN = 1'b0;

        // addi chain with extreme immediates and x0 writes
        clearRom();
        rom[0] <= addiWord(5'd1, 5'd0, 12'd5);
        rom[1] <= addiWord(5'd2, 5'd1, 12'hFFD);
        rom[2] <= addiWord(5'd3, 5'd2, 12'h7FF);
        rom[3] <= addiWord(5'd4, 5'd3, 12'h800);
        rom[4] <= addiWord(5'd0, 5'd1, 12'd100);
        rom[5] <= addiWord(5'd5, 5'd0, 12'd7);
        rom[6] <= addiWord(5'd6, 5'd5, 12'hFFF);
        rom[7] <= ebreakInst;
        resetCore();
        runToHalt(haltEbreak, "addi chain");

        // jalr links and odd targets that skip word 3
        clearRom();
        rom[0] <= jalrWord(5'd1, 5'd0, 12'd4);
        rom[1] <= addiWord(5'd2, 5'd1, 12'd0);
        rom[2] <= jalrWord(5'd3, 5'd2, 12'd13);
        rom[3] <= addiWord(5'd9, 5'd0, 12'd99);
        rom[4] <= jalrWord(5'd0, 5'd1, 12'd17);
        rom[5] <= addiWord(5'd4, 5'd3, 12'hFF4);
        rom[6] <= ebreakInst;
        resetCore();
        runToHalt(haltEbreak, "jalr");

        // addi opcode with funct3 001
        clearRom();
        rom[0] <= addiWord(5'd1, 5'd0, 12'd1);
        rom[1] <= 32'h0010_9093;
        resetCore();
        runToHalt(haltIllegal, "illegal funct3");

        // ecall as a SYSTEM word other than ebreak
        clearRom();
        rom[0] <= addiWord(5'd1, 5'd0, 12'hFFF);
        rom[1] <= addiWord(5'd2, 5'd1, 12'd1);
        rom[2] <= 32'h0000_0073;
        resetCore();
        runToHalt(haltIllegal, "ecall");

        repeat (3) begin
            clearRom();
            loadRandomProgram();
            resetCore();
            runToHalt(haltEbreak, "random");
        end

        $display("Errors: %0d, commits checked: %0d", errors, commits);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
src/npcPkg.sv
src/npcPc.sv
src/npcDecoder.sv
src/npcRegFile.sv
src/npcExecute.sv
src/npcControl.sv
src/npcCore.sv
verif/npcCoreTb.sv

// ==== Bender.yml ====
package:
  name: npc_core

sources:
  - src/npcPkg.sv
  - src/npcPc.sv
  - src/npcDecoder.sv
  - src/npcRegFile.sv
  - src/npcExecute.sv
  - src/npcControl.sv
  - src/npcCore.sv
  - target: test
    files:
      - verif/npcCoreTb.sv
